// ==== mem_stage_config.svh ====
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// number of direct-mapped cache lines, power of two
`define MS_CACHE_LINES 8

// byte address width of the stage and the memory port
`define MS_ADDR_W 32

// cycles a handshake wait may take before the testbench gives up
`define MS_TIMEOUT 200

`endif

// ==== mem_stage_pkg.sv ====
`include "mem_stage_config.svh"

package mem_stage_pkg;

    // where an execute operand is taken from
    typedef enum logic [2:0] {
        SRC_REG1 = 3'd0,
        SRC_REG2 = 3'd1,
        SRC_REG3 = 3'd2,
        SRC_REG4 = 3'd3,
        SRC_IMM  = 3'd4,
        SRC_EIP  = 3'd5,
        SRC_MEM  = 3'd6,
        SRC_ZERO = 3'd7
    } opsrc_t;

    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_t;

    // decoded instruction as accepted from the previous stage
    typedef struct packed {
        access_t               access;
        logic                  is_rep;
        // 0 steps up, 1 steps down
        logic                  dir;
        logic [`MS_ADDR_W-1:0] addr;
        logic [31:0]           reg1;
        logic [31:0]           reg2;
        // repeat count for string ops
        logic [31:0]           reg3;
        logic [31:0]           reg4;
        logic [31:0]           imm;
        logic [31:0]           eip;
        opsrc_t                op1_src;
        opsrc_t                op2_src;
    } mem_inst_t;

    // one beat towards execute
    typedef struct packed {
        logic [31:0]           op1;
        logic [31:0]           op2;
        logic [`MS_ADDR_W-1:0] addr;
        logic                  last;
    } mem_result_t;

endpackage

// ==== cache_if.sv ====
`timescale 1ns/1ps
`include "mem_stage_config.svh"

// four-phase req/ack link from the repeat sequencer to the data cache
interface cache_if;
    logic                  req;
    logic                  ack;
    logic                  we;
    logic [`MS_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
    // valid while ack is high
    logic [31:0]           rdata;

    modport sequencer (
        output req,
        output we,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport cache (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );
endinterface

// ==== rep_addr_gen.sv ====
`timescale 1ns/1ps
`include "mem_stage_config.svh"

module rep_addr_gen (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_req,
    output logic                     in_ack,
    input  mem_stage_pkg::mem_inst_t inst,
    cache_if.sequencer               cache,
    input  logic [31:0]              store_data,
    output logic [31:0]              load_data,
    output logic [`MS_ADDR_W-1:0]    beat_addr,
    output logic                     beat_req,
    input  logic                     beat_ack,
    output logic                     beat_last,
    output mem_stage_pkg::mem_inst_t inst_q
);
    import mem_stage_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CAPT,
        S_ACCESS,
        S_ACC_REL,
        S_BEAT,
        S_BEAT_REL
    } state_t;

    state_t                state;
    logic [31:0]           count_q;
    logic [`MS_ADDR_W-1:0] addr_q;
    logic [`MS_ADDR_W-1:0] incdec;
    logic [31:0]           load_q;
    logic                  accept;

    // only take a new instruction once the previous ack cycle has closed
    assign accept = (state == S_IDLE) && in_req && !in_ack;

    // word step, down when the direction bit is set
    assign incdec = inst_q.dir ? `MS_ADDR_W'(-4) : `MS_ADDR_W'(4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            in_ack  <= 1'b0;
            count_q <= '0;
            addr_q  <= '0;
        end else begin
            // input ack runs on its own so the producer can release early
            if (accept) begin
                in_ack <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (accept) begin
                        addr_q  <= inst.addr;
                        count_q <= inst.is_rep ? inst.reg3 : 32'd1;
                        state   <= S_CAPT;
                    end
                end
                S_CAPT: begin
                    // zero count or no access still gives a single beat
                    if (count_q == 32'd0 || inst_q.access == ACC_NONE) begin
                        state <= S_BEAT;
                    end else begin
                        state <= S_ACCESS;
                    end
                end
                S_ACCESS: begin
                    if (cache.ack) begin
                        state <= S_ACC_REL;
                    end
                end
                S_ACC_REL: begin
                    if (!cache.ack) begin
                        state <= S_BEAT;
                    end
                end
                S_BEAT: begin
                    if (beat_ack) begin
                        state <= S_BEAT_REL;
                    end
                end
                S_BEAT_REL: begin
                    if (!beat_ack) begin
                        if (beat_last) begin
                            state <= S_IDLE;
                        end else begin
                            count_q <= count_q - 32'd1;
                            addr_q  <= addr_q + incdec;
                            state   <= S_CAPT;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= inst;
        end
        // memory operand reads as zero unless a load returned data
        if (state == S_CAPT) begin
            load_q <= '0;
        end else if (state == S_ACCESS && cache.ack && inst_q.access == ACC_LOAD) begin
            load_q <= cache.rdata;
        end
    end

    assign cache.req   = (state == S_ACCESS);
    assign cache.we    = (inst_q.access == ACC_STORE);
    assign cache.addr  = addr_q;
    assign cache.wdata = store_data;

    assign beat_req  = (state == S_BEAT);
    assign beat_last = (count_q <= 32'd1);
    assign beat_addr = addr_q;
    assign load_data = load_q;

endmodule

// ==== dcache.sv ====
`timescale 1ns/1ps
`include "mem_stage_config.svh"

module dcache (
    input  logic                  clk,
    input  logic                  arst_n,
    cache_if.cache                cpu,
    output logic                  mem_req,
    input  logic                  mem_ack,
    output logic                  mem_we,
    output logic [`MS_ADDR_W-1:0] mem_addr,
    output logic [31:0]           mem_wdata,
    input  logic [31:0]           mem_rdata
);
    localparam int LINES = `MS_CACHE_LINES;
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = `MS_ADDR_W - IDX_W - 2;

    typedef enum logic [1:0] {
        C_IDLE,
        C_MEM,
        C_ACK
    } cstate_t;

    cstate_t          state;
    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [LINES];
    logic [31:0]      data_q [LINES];
    logic [31:0]      rdata_q;
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             hit;
    logic             read_hit;

    // word addressed, index sits just above the byte offset
    assign idx      = cpu.addr[IDX_W+1:2];
    assign tag      = cpu.addr[`MS_ADDR_W-1:IDX_W+2];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);
    assign read_hit = cpu.req && !cpu.we && hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= C_IDLE;
            valid_q <= '0;
        end else begin
            case (state)
                C_IDLE: begin
                    // stores always go out to memory
                    if (cpu.req) begin
                        state <= read_hit ? C_ACK : C_MEM;
                    end
                end
                C_MEM: begin
                    if (mem_ack) begin
                        if (!cpu.we) begin
                            valid_q[idx] <= 1'b1;
                        end
                        state <= C_ACK;
                    end
                end
                C_ACK: begin
                    // both sides must be back to idle before the next request
                    if (!cpu.req && !mem_ack) begin
                        state <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == C_IDLE && read_hit) begin
            rdata_q <= data_q[idx];
        end
        if (state == C_MEM && mem_ack) begin
            if (!cpu.we) begin
                // read miss fills the line
                tag_q[idx]  <= tag;
                data_q[idx] <= mem_rdata;
                rdata_q     <= mem_rdata;
            end else if (hit) begin
                // write through, no allocate on a miss
                data_q[idx] <= cpu.wdata;
            end
        end
    end

    assign cpu.ack   = (state == C_ACK);
    assign cpu.rdata = rdata_q;

    // request fields are held by the sequencer until ack
    assign mem_req   = (state == C_MEM);
    assign mem_we    = cpu.we;
    assign mem_addr  = cpu.addr;
    assign mem_wdata = cpu.wdata;

endmodule

// ==== opswap.sv ====
`timescale 1ns/1ps

module opswap (
    input  mem_stage_pkg::mem_inst_t inst,
    input  logic [31:0]              load_data,
    output logic [31:0]              op1,
    output logic [31:0]              op2
);
    import mem_stage_pkg::*;

    // one source decode shared by both operands
    function automatic logic [31:0] pick(
        input opsrc_t      src,
        input mem_inst_t   i,
        input logic [31:0] ld
    );
        logic [31:0] val;
        case (src)
            SRC_REG1: val = i.reg1;
            SRC_REG2: val = i.reg2;
            SRC_REG3: val = i.reg3;
            SRC_REG4: val = i.reg4;
            SRC_IMM:  val = i.imm;
            SRC_EIP:  val = i.eip;
            SRC_MEM:  val = ld;
            default:  val = '0;
        endcase
        return val;
    endfunction

    // op2 doubles as store data on the way back to the sequencer
    assign op1 = pick(inst.op1_src, inst, load_data);
    assign op2 = pick(inst.op2_src, inst, load_data);

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_stage_config.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_req,
    output logic                   in_ack,
    input  mem_stage_pkg::access_t in_access,
    input  logic                   in_is_rep,
    input  logic                   in_dir,
    input  logic [`MS_ADDR_W-1:0]  in_addr,
    input  logic [31:0]            in_reg1,
    input  logic [31:0]            in_reg2,
    input  logic [31:0]            in_reg3,
    input  logic [31:0]            in_reg4,
    input  logic [31:0]            in_imm,
    input  logic [31:0]            in_eip,
    input  mem_stage_pkg::opsrc_t  in_op1_src,
    input  mem_stage_pkg::opsrc_t  in_op2_src,
    output logic                   out_req,
    input  logic                   out_ack,
    output logic [31:0]            out_op1,
    output logic [31:0]            out_op2,
    output logic [`MS_ADDR_W-1:0]  out_addr,
    output logic                   out_last,
    output logic                   mem_req,
    input  logic                   mem_ack,
    output logic                   mem_we,
    output logic [`MS_ADDR_W-1:0]  mem_addr,
    output logic [31:0]            mem_wdata,
    input  logic [31:0]            mem_rdata
);
    import mem_stage_pkg::*;

    mem_inst_t             inst;
    mem_inst_t             inst_q;
    mem_result_t           result;
    logic [31:0]           load_data;
    logic [31:0]           op1;
    logic [31:0]           op2;
    logic [`MS_ADDR_W-1:0] beat_addr;
    logic                  beat_last;

    cache_if u_cache_if ();

    always_comb begin
        inst.access  = in_access;
        inst.is_rep  = in_is_rep;
        inst.dir     = in_dir;
        inst.addr    = in_addr;
        inst.reg1    = in_reg1;
        inst.reg2    = in_reg2;
        inst.reg3    = in_reg3;
        inst.reg4    = in_reg4;
        inst.imm     = in_imm;
        inst.eip     = in_eip;
        inst.op1_src = in_op1_src;
        inst.op2_src = in_op2_src;
    end

    rep_addr_gen u_rep_addr_gen (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .inst       (inst),
        .cache      (u_cache_if.sequencer),
        .store_data (op2),
        .load_data  (load_data),
        .beat_addr  (beat_addr),
        .beat_req   (out_req),
        .beat_ack   (out_ack),
        .beat_last  (beat_last),
        .inst_q     (inst_q)
    );

    // operands come from the captured copy, stable for the whole beat
    opswap u_opswap (
        .inst      (inst_q),
        .load_data (load_data),
        .op1       (op1),
        .op2       (op2)
    );

    dcache u_dcache (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu       (u_cache_if.cache),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    assign result = '{op1: op1, op2: op2, addr: beat_addr, last: beat_last};

    assign out_op1  = result.op1;
    assign out_op2  = result.op2;
    assign out_addr = result.addr;
    assign out_last = result.last;

endmodule

// ==== mem_stage_tb.sv ====
`timescale 1ns/1ps
`include "mem_stage_config.svh"

module mem_stage_tb;
    import mem_stage_pkg::*;

    logic                  clk = 1'b0;
    logic                  arst_n, in_req, in_ack, in_is_rep, in_dir;
    access_t               in_access;
    logic [`MS_ADDR_W-1:0] in_addr, out_addr, mem_addr;
    logic [31:0]           in_reg1, in_reg2, in_reg3, in_reg4, in_imm, in_eip;
    opsrc_t                in_op1_src, in_op2_src;
    logic                  out_req, out_ack, out_last, mem_req, mem_ack, mem_we;
    logic [31:0]           out_op1, out_op2, mem_wdata, mem_rdata;

    // external memory and the contents it is expected to hold
    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    // tag model of the direct-mapped cache, index is address bits [4:2]
    logic [7:0]  model_valid;
    logic [26:0] model_tag [8];
    integer      seed = 32'hf988_e51b;
    int          req_count = 0;
    int          wr_count = 0;
    int          err_count = 0;
    int          test_count = 0;
    int          bad_tests = 0;

    mem_stage u_mem_stage (.*);

    always #2 clk = ~clk;

    always @(posedge mem_req) begin
        req_count++;
        if (mem_we) begin
            wr_count++;
        end
    end

    // memory answers each request after 0 to 3 cycles
    initial begin : responder
        int delay;
        mem_ack = 1'b0;
        mem_rdata = 32'd0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a00_0000 + i * 32'h0001_0003;
        end
        forever begin
            @(negedge clk);
            if (mem_req && !mem_ack) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
                if (mem_we) begin
                    mem[mem_addr[9:2]] = mem_wdata;
                end
                mem_rdata = mem[mem_addr[9:2]];
                mem_ack = 1'b1;
            end else if (!mem_req && mem_ack) begin
                mem_ack = 1'b0;
            end
        end
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic wait_level(input logic on_out, input logic level, input string what);
        int n;
        n = 0;
        while ((on_out ? out_req : in_ack) !== level && n < `MS_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if ((on_out ? out_req : in_ack) !== level) begin
            $display("timeout at %0t: %s not seen within %0d cycles", $time, what, `MS_TIMEOUT);
            $display("Simulation failed");
            $finish;
        end
    endtask

    // value an operand source should give, md is the loaded word
    function automatic logic [31:0] src_value(input opsrc_t src, input logic [31:0] md);
        case (src)
            SRC_REG1: return in_reg1;
            SRC_REG2: return in_reg2;
            SRC_REG3: return in_reg3;
            SRC_REG4: return in_reg4;
            SRC_IMM:  return in_imm;
            SRC_EIP:  return in_eip;
            SRC_MEM:  return md;
            default:  return 32'd0;
        endcase
    endfunction

    // returns 1 when the access must reach the memory port
    function automatic int predict_mem(input logic [31:0] a, input logic is_load);
        int need;
        need = 1;
        if (is_load) begin
            if (model_valid[a[4:2]] && model_tag[a[4:2]] == a[31:5]) begin
                need = 0;
            end
            model_valid[a[4:2]] = 1'b1;
            model_tag[a[4:2]] = a[31:5];
        end
        return need;
    endfunction

    task automatic send_inst(input access_t acc, input logic rep, input logic dir,
                             input logic [31:0] addr, input logic [31:0] count,
                             input opsrc_t s1, input opsrc_t s2);
        @(negedge clk);
        in_access = acc;
        in_is_rep = rep;
        in_dir = dir;
        in_addr = addr;
        in_reg3 = count;
        in_op1_src = s1;
        in_op2_src = s2;
        in_req = 1'b1;
        wait_level(1'b0, 1'b1, "in_ack high");
        in_req = 1'b0;
        wait_level(1'b0, 1'b0, "in_ack low");
    endtask

    task automatic take_beat(output logic [31:0] op1, output logic [31:0] op2,
                             output logic [31:0] addr, output logic last);
        wait_level(1'b1, 1'b1, "out_req high");
        op1 = out_op1;
        op2 = out_op2;
        addr = out_addr;
        last = out_last;
        out_ack = 1'b1;
        wait_level(1'b1, 1'b0, "out_req low");
        out_ack = 1'b0;
    endtask

    // consumer keeps out_ack low while the beat must stay put
    task automatic hold_beat(input int cycles);
        logic [31:0] op1, op2, addr;
        logic        last;
        int          r0;
        wait_level(1'b1, 1'b1, "out_req high");
        op1 = out_op1;
        op2 = out_op2;
        addr = out_addr;
        last = out_last;
        r0 = req_count;
        repeat (cycles) begin
            @(negedge clk);
            check_flag("out_req", out_req, 1'b1);
            check_word("out_op1", out_op1, op1);
            check_word("out_op2", out_op2, op2);
            check_word("out_addr", out_addr, addr);
            check_flag("out_last", out_last, last);
        end
        check_word("mem_req rises while stalled", req_count - r0, 32'd0);
    endtask

    // one instruction with all of its beats checked against the plan rules
    task automatic run_inst(input access_t acc, input logic rep, input logic dir,
                            input logic [31:0] base, input logic [31:0] count,
                            input opsrc_t s1, input opsrc_t s2, input int stall_at);
        int          beats, exp_req, r0;
        logic        no_access, last;
        logic [31:0] a, md, op1, op2, addr;
        beats = (rep && count != 0) ? int'(count) : 1;
        no_access = (acc == ACC_NONE) || (rep && count == 0);
        exp_req = 0;
        r0 = req_count;
        a = base;
        send_inst(acc, rep, dir, base, count, s1, s2);
        for (int k = 0; k < beats; k++) begin
            md = 32'd0;
            if (!no_access) begin
                exp_req += predict_mem(a, acc == ACC_LOAD);
                if (acc == ACC_LOAD) begin
                    md = ref_mem[a[9:2]];
                end else begin
                    ref_mem[a[9:2]] = src_value(s2, 32'd0);
                end
            end
            if (k == stall_at) begin
                hold_beat(20);
            end
            take_beat(op1, op2, addr, last);
            check_word("out_addr", addr, a);
            check_word("out_op1", op1, src_value(s1, md));
            check_word("out_op2", op2, src_value(s2, md));
            check_flag("out_last", last, k == beats - 1);
            a = dir ? a - 4 : a + 4;
        end
        check_word("mem_req rises", req_count - r0, exp_req);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - errs_before);
            bad_tests++;
        end
    endtask

    task automatic test_operands();
        int e0;
        e0 = err_count;
        for (int a = 0; a < 8; a++) begin
            for (int b = 0; b < 8; b++) begin
                run_inst(ACC_NONE, 1'b0, 1'b0, 32'h40 + 32'(a * 4), 32'h3333_0003,
                         opsrc_t'(a[2:0]), opsrc_t'(b[2:0]), -1);
            end
        end
        end_test("operand selection", e0);
    endtask

    task automatic test_load_cache();
        int e0, r0;
        e0 = err_count;
        r0 = req_count;
        run_inst(ACC_LOAD, 1'b0, 1'b0, 32'h80, 32'd0, SRC_MEM, SRC_REG1, -1);
        check_word("mem_req rises after first load", req_count - r0, 32'd1);
        run_inst(ACC_LOAD, 1'b0, 1'b0, 32'h80, 32'd0, SRC_MEM, SRC_REG1, -1);
        check_word("mem_req rises after second load", req_count - r0, 32'd1);
        end_test("load and cache", e0);
    endtask

    task automatic test_rep_store_load();
        int e0, w0;
        e0 = err_count;
        w0 = wr_count;
        in_imm = 32'hc0de_0005;
        run_inst(ACC_STORE, 1'b1, 1'b0, 32'h100, 32'd5, SRC_REG1, SRC_IMM, -1);
        check_word("memory writes", wr_count - w0, 32'd5);
        for (int k = 64; k < 69; k++) begin
            check_word("memory word", mem[k], ref_mem[k]);
        end
        // walk back down over the same five words
        run_inst(ACC_LOAD, 1'b1, 1'b1, 32'h110, 32'd5, SRC_MEM, SRC_EIP, -1);
        check_word("memory writes after load", wr_count - w0, 32'd5);
        end_test("repeat store and load", e0);
    endtask

    task automatic test_conflict();
        int e0, r0;
        e0 = err_count;
        r0 = req_count;
        // same index 1, tags differ
        for (int k = 0; k < 4; k++) begin
            run_inst(ACC_LOAD, 1'b0, 1'b0, 32'h044, 32'd0, SRC_MEM, SRC_ZERO, -1);
            run_inst(ACC_LOAD, 1'b0, 1'b0, 32'h244, 32'd0, SRC_MEM, SRC_ZERO, -1);
        end
        check_word("conflict misses", req_count - r0, 32'd8);
        end_test("conflict misses", e0);
    endtask

    task automatic test_zero_stall();
        int e0;
        e0 = err_count;
        run_inst(ACC_LOAD, 1'b1, 1'b0, 32'h380, 32'd0, SRC_MEM, SRC_REG2, -1);
        run_inst(ACC_LOAD, 1'b1, 1'b0, 32'h300, 32'd4, SRC_MEM, SRC_REG4, 1);
        end_test("zero count and back-pressure", e0);
    endtask

    initial begin
        arst_n = 1'b0;
        in_req = 1'b0;
        in_access = ACC_NONE;
        in_is_rep = 1'b0;
        in_dir = 1'b0;
        in_addr = '0;
        in_reg1 = 32'ha1a1_0001;
        in_reg2 = 32'hb2b2_0002;
        in_reg3 = 32'd0;
        in_reg4 = 32'hd4d4_0004;
        in_imm = 32'h0000_1234;
        in_eip = 32'h0040_1000;
        in_op1_src = SRC_ZERO;
        in_op2_src = SRC_ZERO;
        out_ack = 1'b0;
        model_valid = '0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        ref_mem = mem;
        test_operands();
        test_load_cache();
        test_rep_store_load();
        test_conflict();
        test_zero_stall();
        $display("tests %0d, failing tests %0d, errors %0d", test_count, bad_tests, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== mem_stage.f ====
+incdir+.
mem_stage_pkg.sv
cache_if.sv
rep_addr_gen.sv
dcache.sv
opswap.sv
mem_stage.sv
mem_stage_tb.sv

// ==== Makefile ====
TOP := mem_stage_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f mem_stage.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing -f mem_stage.f --top-module $(TOP)

clean:
	rm -rf obj_dir
